/* hdl/cache_pkg.sv */
package cache_pkg;

	// ------------------------------
	// Address and data geometry
	// ------------------------------
	localparam int ADDR_W     = 12;
	localparam int DATA_W     = 32;
	localparam int OFFSET_W   = 2;
	localparam int INDEX_W    = 8;
	localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

	// Cache organisation
	localparam int LINE_WORDS = 1 << OFFSET_W;
	localparam int WAYS       = 2;
	localparam int SETS       = 1 << INDEX_W;

	// Last word of a line, end of refill
	localparam logic [OFFSET_W-1:0] LAST_WORD = OFFSET_W'(LINE_WORDS - 1);

	// ------------------------------
	// Main memory model
	// ------------------------------
	localparam int MEM_WORDS   = 1 << ADDR_W;
	localparam int MEM_LATENCY = 3;
	localparam int MEM_CNT_W   = $clog2(MEM_LATENCY + 1);
	// Start value of the latency countdown
	localparam logic [MEM_CNT_W-1:0] MEM_CNT_INIT = MEM_CNT_W'(MEM_LATENCY);

	// Processor opcode, write is 1 as on the cpu_op pin
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} cache_op_e;

	// Execute FSM
	typedef enum logic [2:0] {
		EX_IDLE,
		EX_LOOKUP,
		EX_REFILL,
		EX_WRITE,
		EX_RESPOND
	} exec_state_e;

	// Main memory FSM
	typedef enum logic [1:0] {
		MS_IDLE,
		MS_WAIT,
		MS_ACK
	} mem_state_e;

endpackage

/* hdl/cache_ifs.sv */
`timescale 1ns/100ps

// ------------------------------
// Decode to execute
// ------------------------------
interface lookup_if;
	logic                            valid;
	cache_pkg::cache_op_e            op;
	logic [cache_pkg::TAG_W-1:0]     tag;
	logic [cache_pkg::INDEX_W-1:0]   index;
	logic [cache_pkg::OFFSET_W-1:0]  offset;
	logic [cache_pkg::DATA_W-1:0]    wdata;
	// Execute has latched the request
	logic                            taken;

	modport source (output valid, op, tag, index, offset, wdata, input taken);
	modport sink (input valid, op, tag, index, offset, wdata, output taken);
endinterface

// ------------------------------
// Execute to result
// ------------------------------
interface resp_if;
	// One-cycle pulse
	logic                          valid;
	logic                          hit;
	logic [cache_pkg::DATA_W-1:0]  rdata;
	// No response held or acknowledged
	logic                          idle;

	modport source (output valid, hit, rdata, input idle);
	modport sink (input valid, hit, rdata, output idle);
	// Decode only needs idle
	modport observer (input idle);
endinterface

// ------------------------------
// Execute to main memory
// ------------------------------
interface mem_if;
	// Four-phase, same as the processor port
	logic                          req;
	logic                          we;
	logic [cache_pkg::ADDR_W-1:0]  addr;
	logic [cache_pkg::DATA_W-1:0]  wdata;
	logic                          ack;
	logic [cache_pkg::DATA_W-1:0]  rdata;

	modport master (output req, we, addr, wdata, input ack, rdata);
	modport slave (input req, we, addr, wdata, output ack, rdata);
endinterface

/* hdl/cache_decode.sv */
`timescale 1ns/100ps

module cache_decode (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          req,
	input  logic                          op,
	input  logic [cache_pkg::ADDR_W-1:0]  addr,
	input  logic [cache_pkg::DATA_W-1:0]  wdata,
	lookup_if.source                      lookup,
	resp_if.observer                      resp
);

	// Request registers
	cache_pkg::cache_op_e            op_q;
	logic [cache_pkg::ADDR_W-1:0]    addr_q;
	logic [cache_pkg::DATA_W-1:0]    wdata_q;

	// Control
	logic valid_q;
	logic pending_q;
	logic accept;

	// New request only when nothing in flight and the last handshake closed
	assign accept = req && !pending_q && resp.idle;

	// ------------------------------
	// Control state
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q   <= 1'b0;
			pending_q <= 1'b0;
		end else begin
			if (accept) begin
				valid_q   <= 1'b1;
				pending_q <= 1'b1;
			end else if (lookup.taken) begin
				valid_q <= 1'b0;
			end
			// Response captured, so the held req is already served
			if (!resp.idle)
				pending_q <= 1'b0;
		end
	end

	// Payload capture
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q    <= op ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
			addr_q  <= addr;
			wdata_q <= wdata;
		end
	end

	// ------------------------------
	// Address split
	// ------------------------------
	assign lookup.valid  = valid_q;
	assign lookup.op     = op_q;
	assign lookup.tag    = addr_q[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
	assign lookup.index  = addr_q[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
	assign lookup.offset = addr_q[cache_pkg::OFFSET_W-1:0];
	assign lookup.wdata  = wdata_q;

endmodule

/* hdl/cache_execute.sv */
`timescale 1ns/100ps

module cache_execute (
	input  logic       clk,
	input  logic       rst_n,
	lookup_if.sink     lookup,
	mem_if.master      mem,
	resp_if.source     resp
);

	// ------------------------------
	// Storage
	// ------------------------------
	logic [cache_pkg::TAG_W-1:0]   tag_mem  [cache_pkg::WAYS][cache_pkg::SETS];
	logic [cache_pkg::DATA_W-1:0]  data_mem [cache_pkg::WAYS][cache_pkg::SETS]
	                                        [cache_pkg::LINE_WORDS];
	logic [cache_pkg::SETS-1:0]    valid_q  [cache_pkg::WAYS];
	// Way to replace next, per set
	logic [cache_pkg::SETS-1:0]    lru_q;

	// Latched request
	cache_pkg::cache_op_e            req_op;
	logic [cache_pkg::TAG_W-1:0]     req_tag;
	logic [cache_pkg::INDEX_W-1:0]   req_index;
	logic [cache_pkg::OFFSET_W-1:0]  req_offset;
	logic [cache_pkg::DATA_W-1:0]    req_wdata;

	// Control
	cache_pkg::exec_state_e          state;
	logic                            mem_req_q;
	logic [cache_pkg::OFFSET_W-1:0]  refill_cnt;
	logic                            victim_q;
	logic                            resp_valid_q;
	logic                            resp_hit_q;
	logic [cache_pkg::DATA_W-1:0]    resp_rdata_q;

	// Lookup results
	logic                            hit0;
	logic                            hit1;
	logic                            hit_any;
	logic                            hit_way;
	logic [cache_pkg::DATA_W-1:0]    hit_word;
	logic                            is_write;

	// Strobes shared by the two register blocks
	logic take;
	logic in_lookup;
	logic mem_done;
	logic refill_store;
	logic refill_done;

	// ------------------------------
	// Hit detection
	// ------------------------------
	assign hit0     = valid_q[0][req_index] && (tag_mem[0][req_index] == req_tag);
	assign hit1     = valid_q[1][req_index] && (tag_mem[1][req_index] == req_tag);
	assign hit_any  = hit0 || hit1;
	assign hit_way  = hit1;
	assign hit_word = data_mem[hit_way][req_index][req_offset];
	assign is_write = (req_op == cache_pkg::OP_WRITE);

	assign take         = (state == cache_pkg::EX_IDLE) && lookup.valid;
	assign in_lookup    = (state == cache_pkg::EX_LOOKUP);
	// Memory handshake fully closed
	assign mem_done     = !mem_req_q && !mem.ack;
	assign refill_store = (state == cache_pkg::EX_REFILL) && mem_req_q && mem.ack;
	assign refill_done  = (state == cache_pkg::EX_REFILL) && mem_done &&
	                      (refill_cnt == cache_pkg::LAST_WORD);

	assign lookup.taken = take;

	// Memory port, refill walks the line from word 0
	assign mem.req   = mem_req_q;
	assign mem.we    = (state == cache_pkg::EX_WRITE);
	assign mem.addr  = (state == cache_pkg::EX_WRITE) ?
	                   {req_tag, req_index, req_offset} :
	                   {req_tag, req_index, refill_cnt};
	assign mem.wdata = req_wdata;

	assign resp.valid = resp_valid_q;
	assign resp.hit   = resp_hit_q;
	assign resp.rdata = resp_rdata_q;

	// ------------------------------
	// FSM, valid and LRU bits
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= cache_pkg::EX_IDLE;
			valid_q[0]   <= '0;
			valid_q[1]   <= '0;
			lru_q        <= '0;
			mem_req_q    <= 1'b0;
			refill_cnt   <= '0;
			victim_q     <= 1'b0;
			resp_valid_q <= 1'b0;
		end else begin
			// Pulse
			resp_valid_q <= 1'b0;
			case (state)
				cache_pkg::EX_IDLE: begin
					if (lookup.valid)
						state <= cache_pkg::EX_LOOKUP;
				end
				cache_pkg::EX_LOOKUP: begin
					// Touched way becomes most recent
					if (hit_any)
						lru_q[req_index] <= !hit_way;
					if (is_write) begin
						mem_req_q <= 1'b1;
						state     <= cache_pkg::EX_WRITE;
					end else if (hit_any) begin
						resp_valid_q <= 1'b1;
						state        <= cache_pkg::EX_RESPOND;
					end else begin
						// Read miss, refill the LRU way
						victim_q   <= lru_q[req_index];
						refill_cnt <= '0;
						mem_req_q  <= 1'b1;
						state      <= cache_pkg::EX_REFILL;
					end
				end
				cache_pkg::EX_REFILL: begin
					if (mem_req_q && mem.ack) begin
						mem_req_q <= 1'b0;
					end else if (refill_done) begin
						valid_q[victim_q][req_index] <= 1'b1;
						lru_q[req_index]             <= !victim_q;
						resp_valid_q                 <= 1'b1;
						state                        <= cache_pkg::EX_RESPOND;
					end else if (mem_done) begin
						// Next word of the line
						refill_cnt <= refill_cnt + 1'b1;
						mem_req_q  <= 1'b1;
					end
				end
				cache_pkg::EX_WRITE: begin
					if (mem_req_q && mem.ack) begin
						mem_req_q <= 1'b0;
					end else if (mem_done) begin
						resp_valid_q <= 1'b1;
						state        <= cache_pkg::EX_RESPOND;
					end
				end
				cache_pkg::EX_RESPOND: begin
					// Wait for result to finish the processor handshake
					if (resp.idle && !resp_valid_q)
						state <= cache_pkg::EX_IDLE;
				end
				default: state <= cache_pkg::EX_IDLE;
			endcase
		end
	end

	// ------------------------------
	// Arrays and payload
	// ------------------------------
	always_ff @(posedge clk) begin
		if (take) begin
			req_op     <= lookup.op;
			req_tag    <= lookup.tag;
			req_index  <= lookup.index;
			req_offset <= lookup.offset;
			req_wdata  <= lookup.wdata;
		end
		if (in_lookup) begin
			resp_hit_q <= hit_any;
			if (is_write) begin
				// Write data echoed back
				resp_rdata_q <= req_wdata;
				if (hit_any)
					data_mem[hit_way][req_index][req_offset] <= req_wdata;
			end else begin
				resp_rdata_q <= hit_word;
			end
		end
		if (refill_store) begin
			data_mem[victim_q][req_index][refill_cnt] <= mem.rdata;
			// Requested word goes straight to the response
			if (refill_cnt == req_offset)
				resp_rdata_q <= mem.rdata;
		end
		if (refill_done)
			tag_mem[victim_q][req_index] <= req_tag;
	end

endmodule

/* hdl/cache_result.sv */
`timescale 1ns/100ps

module cache_result (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          req,
	resp_if.sink                          resp,
	output logic                          ack,
	output logic [cache_pkg::DATA_W-1:0]  rdata,
	output logic                          hit
);

	// Held response
	logic [cache_pkg::DATA_W-1:0] rdata_q;
	logic                         hit_q;
	logic                         ack_q;

	// ------------------------------
	// Processor handshake
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			if (resp.valid)
				ack_q <= 1'b1;
			// Close once the processor lets go of req
			else if (ack_q && !req)
				ack_q <= 1'b0;
		end
	end

	// Capture on the execute pulse
	always_ff @(posedge clk) begin
		if (resp.valid) begin
			rdata_q <= resp.rdata;
			hit_q   <= resp.hit;
		end
	end

	// Busy from capture until ack drops
	assign resp.idle = !ack_q;

	assign ack   = ack_q;
	assign rdata = rdata_q;
	assign hit   = hit_q;

endmodule

/* hdl/main_memory.sv */
`timescale 1ns/100ps

module main_memory (
	input  logic   clk,
	input  logic   rst_n,
	mem_if.slave   mem
);

	// Word storage, contents undefined until written
	logic [cache_pkg::DATA_W-1:0]    mem_q [cache_pkg::MEM_WORDS];
	logic [cache_pkg::DATA_W-1:0]    rdata_q;

	cache_pkg::mem_state_e           state;
	logic [cache_pkg::MEM_CNT_W-1:0] cnt_q;
	logic                            ack_q;
	logic                            access;

	// Latency elapsed, do the access this cycle
	assign access = (state == cache_pkg::MS_WAIT) && (cnt_q == 1);

	// ------------------------------
	// Latency and handshake
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cache_pkg::MS_IDLE;
			cnt_q <= '0;
			ack_q <= 1'b0;
		end else begin
			case (state)
				cache_pkg::MS_IDLE: begin
					if (mem.req) begin
						cnt_q <= cache_pkg::MEM_CNT_INIT;
						state <= cache_pkg::MS_WAIT;
					end
				end
				cache_pkg::MS_WAIT: begin
					if (access) begin
						ack_q <= 1'b1;
						state <= cache_pkg::MS_ACK;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				cache_pkg::MS_ACK: begin
					// Drop ack after req falls
					if (!mem.req) begin
						ack_q <= 1'b0;
						state <= cache_pkg::MS_IDLE;
					end
				end
				default: state <= cache_pkg::MS_IDLE;
			endcase
		end
	end

	// Array access
	always_ff @(posedge clk) begin
		if (access) begin
			if (mem.we)
				mem_q[mem.addr] <= mem.wdata;
			rdata_q <= mem_q[mem.addr];
		end
	end

	assign mem.ack   = ack_q;
	assign mem.rdata = rdata_q;

endmodule

/* hdl/cache_top.sv */
`timescale 1ns/100ps

module cache_top (
	input  logic                          clk,
	input  logic                          rst_n,
	// Processor port, four-phase
	input  logic                          cpu_req,
	input  logic                          cpu_op,
	input  logic [cache_pkg::ADDR_W-1:0]  cpu_addr,
	input  logic [cache_pkg::DATA_W-1:0]  cpu_wdata,
	output logic                          cpu_ack,
	output logic [cache_pkg::DATA_W-1:0]  cpu_rdata,
	output logic                          cpu_hit
);

	// ------------------------------
	// Internal buses
	// ------------------------------
	lookup_if lookup_bus ();
	resp_if   resp_bus ();
	mem_if    mem_bus ();

	// Request capture and address split
	cache_decode decode0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (cpu_req),
		.op     (cpu_op),
		.addr   (cpu_addr),
		.wdata  (cpu_wdata),
		.lookup (lookup_bus.source),
		.resp   (resp_bus.observer)
	);

	// Arrays, hit logic, refill and write-through
	cache_execute execute0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.lookup (lookup_bus.sink),
		.mem    (mem_bus.master),
		.resp   (resp_bus.source)
	);

	// Response and processor ack
	cache_result result0 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (cpu_req),
		.resp  (resp_bus.sink),
		.ack   (cpu_ack),
		.rdata (cpu_rdata),
		.hit   (cpu_hit)
	);

	// Backing store
	main_memory memory0 (
		.clk   (clk),
		.rst_n (rst_n),
		.mem   (mem_bus.slave)
	);

endmodule

/* verification/cache_checker.sv */
`timescale 1ns/100ps

module cache_checker (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          cpu_req,
	input logic                          cpu_ack,
	input logic [cache_pkg::DATA_W-1:0]  cpu_rdata,
	input logic                          mem_req,
	input logic                          mem_ack
);

	// Failed assertions so far, watched by the testbench
	int failure_count = 0;

	// ------------------------------
	// Processor port
	// ------------------------------
	// Req was high on the edge that raised ack
	cpu_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cpu_ack) |-> $past(cpu_req))
		else begin
			$error("cpu_ack rose while cpu_req was low");
			failure_count++;
		end

	// Ack may only close after req was seen low
	cpu_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cpu_ack) |-> !$past(cpu_req))
		else begin
			$error("cpu_ack fell while cpu_req was still high");
			failure_count++;
		end

	// New request only after the last ack is gone
	cpu_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cpu_req) |-> !cpu_ack)
		else begin
			$error("cpu_req rose while cpu_ack was still high");
			failure_count++;
		end

	cpu_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ack && $past(cpu_ack) |-> $stable(cpu_rdata))
		else begin
			$error("cpu_rdata changed while cpu_ack was high");
			failure_count++;
		end

	// ------------------------------
	// Main memory port
	// ------------------------------
	mem_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_ack) |-> mem_req)
		else begin
			$error("mem ack rose while mem req was low");
			failure_count++;
		end

	mem_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(mem_ack) |-> !$past(mem_req))
		else begin
			$error("mem ack fell while mem req was still high");
			failure_count++;
		end

	mem_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_req) |-> !mem_ack)
		else begin
			$error("mem req rose while mem ack was still high");
			failure_count++;
		end

endmodule

// Memory bus reached through the top's internal interface
bind cache_top cache_checker checker0 (
	.clk       (clk),
	.rst_n     (rst_n),
	.cpu_req   (cpu_req),
	.cpu_ack   (cpu_ack),
	.cpu_rdata (cpu_rdata),
	.mem_req   (mem_bus.req),
	.mem_ack   (mem_bus.ack)
);

/* verification/cache_tb.sv */
`timescale 1ns/100ps

module cache_tb;

	typedef logic [cache_pkg::ADDR_W-1:0] addr_t;
	typedef logic [cache_pkg::DATA_W-1:0] data_t;

	// ------------------------------
	// Timing and run length
	// ------------------------------
	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY  = 2;
	localparam int HIT_LATENCY  = 3;
	localparam int RAND_SEED    = 78708;
	localparam int RAND_OPS     = 60;
	// Transactions per test, in run order
	localparam int TXN_COUNT    = 6 + 8 + 19 + 18 + (32 + RAND_OPS);
	// Refill worst case stays well under 40 cycles
	localparam int CYCLE_LIMIT  = 40 * TXN_COUNT + RESET_CYCLES;

	logic   clk;
	logic   rst_n;
	logic   cpu_req;
	logic   cpu_op;
	addr_t  cpu_addr;
	data_t  cpu_wdata;
	logic   cpu_ack;
	data_t  cpu_rdata;
	logic   cpu_hit;

	// Reference model, memory image plus per-set tags, valid and LRU
	data_t                        shadow_mem  [cache_pkg::MEM_WORDS];
	logic [cache_pkg::TAG_W-1:0]  model_tag   [cache_pkg::WAYS][cache_pkg::SETS];
	logic                         model_valid [cache_pkg::WAYS][cache_pkg::SETS];
	logic                         model_lru   [cache_pkg::SETS];

	int    cycle_count = 0;
	// Address of the transaction in flight, for error lines
	addr_t cur_addr;

	cache_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_req   (cpu_req),
		.cpu_op    (cpu_op),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.cpu_hit   (cpu_hit)
	);

	always #HALF_PERIOD clk = ~clk;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	// Hang guard
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
			fail_run("Timeout: the cache stopped answering requests");
	end

	// Stop at the first failed handshake assertion
	always @(posedge clk) begin
		if (dut0.checker0.failure_count != 0)
			fail_run("A handshake assertion failed");
	end

	task automatic check_value(input string name, input data_t actual, input data_t expected);
		if (actual !== expected) begin
			$display("Error: %s is 0x%0h, expected 0x%0h (address 0x%03h)",
			         name, actual, expected, cur_addr);
			fail_run("Mismatch against the reference model");
		end
	endtask

	// ------------------------------
	// Reference model
	// ------------------------------
	task automatic model_access(input cache_pkg::cache_op_e op, input addr_t addr,
	                            input data_t wdata, output data_t exp_rdata,
	                            output logic exp_hit);
		logic [cache_pkg::TAG_W-1:0]   tag;
		logic [cache_pkg::INDEX_W-1:0] idx;
		logic                          hit0;
		logic                          hit1;
		logic                          victim;
		tag     = addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
		idx     = addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
		hit0    = model_valid[0][idx] && (model_tag[0][idx] == tag);
		hit1    = model_valid[1][idx] && (model_tag[1][idx] == tag);
		exp_hit = hit0 || hit1;
		// Write-through keeps cache and memory equal
		if (op == cache_pkg::OP_WRITE)
			shadow_mem[addr] = wdata;
		exp_rdata = shadow_mem[addr];
		if (exp_hit) begin
			// Other way becomes least recent
			model_lru[idx] = !hit1;
		end else if (op == cache_pkg::OP_READ) begin
			victim                   = model_lru[idx];
			model_tag[victim][idx]   = tag;
			model_valid[victim][idx] = 1'b1;
			model_lru[idx]           = !victim;
		end
	endtask

	// Full four-phase handshake, latency counted from the edge that samples req
	task automatic run_txn(input cache_pkg::cache_op_e op, input addr_t addr,
	                       input data_t wdata, output data_t rdata, output logic hit,
	                       output int latency);
		cur_addr  = addr;
		cpu_op    = (op == cache_pkg::OP_WRITE);
		cpu_addr  = addr;
		cpu_wdata = wdata;
		cpu_req   = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		latency = 0;
		while (!cpu_ack) begin
			@(posedge clk);
			#DRIVE_DELAY;
			latency++;
		end
		rdata   = cpu_rdata;
		hit     = cpu_hit;
		cpu_req = 1'b0;
		while (cpu_ack) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic access_and_check(input cache_pkg::cache_op_e op, input addr_t addr,
	                                input data_t wdata);
		data_t exp_rdata;
		data_t rdata;
		logic  exp_hit;
		logic  hit;
		int    latency;
		model_access(op, addr, wdata, exp_rdata, exp_hit);
		run_txn(op, addr, wdata, rdata, hit, latency);
		check_value("cpu_hit", hit, exp_hit);
		if (op == cache_pkg::OP_READ) begin
			check_value("cpu_rdata", rdata, exp_rdata);
			if (exp_hit)
				check_value("read hit latency", latency, HIT_LATENCY);
		end
	endtask

	function automatic addr_t make_addr(input logic [cache_pkg::TAG_W-1:0] tag,
	                                    input logic [cache_pkg::INDEX_W-1:0] index,
	                                    input logic [cache_pkg::OFFSET_W-1:0] offset);
		return {tag, index, offset};
	endfunction

	// Data tied to every address bit
	function automatic data_t word_pattern(input addr_t addr);
		return {4'hc, addr, ~addr, 4'h3};
	endfunction

	// Four writes, so every word of the line is defined in memory
	task automatic write_line(input int tag, input int index);
		addr_t addr;
		for (int off = 0; off < cache_pkg::LINE_WORDS; off++) begin
			addr = make_addr(tag, index, off);
			access_and_check(cache_pkg::OP_WRITE, addr, word_pattern(addr));
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic test_reset_no_allocate();
		check_value("cpu_ack", cpu_ack, 1'b0);
		write_line(1, 8'h10);
		// Write miss left the set empty
		access_and_check(cache_pkg::OP_READ, make_addr(1, 8'h10, 2), '0);
		access_and_check(cache_pkg::OP_READ, make_addr(1, 8'h10, 2), '0);
	endtask

	task automatic test_line_fill();
		write_line(2, 8'h21);
		// Offset 0 refills, the rest of the line then hits
		for (int off = 0; off < cache_pkg::LINE_WORDS; off++)
			access_and_check(cache_pkg::OP_READ, make_addr(2, 8'h21, off), '0);
	endtask

	task automatic test_lru_replace();
		for (int t = 0; t < 3; t++)
			write_line(t, 8'h35);
		// Three tags fight over two ways
		access_and_check(cache_pkg::OP_READ, make_addr(0, 8'h35, 0), '0);
		access_and_check(cache_pkg::OP_READ, make_addr(1, 8'h35, 1), '0);
		access_and_check(cache_pkg::OP_READ, make_addr(0, 8'h35, 2), '0);
		access_and_check(cache_pkg::OP_READ, make_addr(2, 8'h35, 3), '0);
		access_and_check(cache_pkg::OP_READ, make_addr(0, 8'h35, 1), '0);
		access_and_check(cache_pkg::OP_READ, make_addr(1, 8'h35, 2), '0);
		access_and_check(cache_pkg::OP_READ, make_addr(2, 8'h35, 0), '0);
	endtask

	task automatic test_write_hit();
		addr_t addr;
		addr = make_addr(3, 8'h47, 1);
		write_line(3, 8'h47);
		access_and_check(cache_pkg::OP_READ, addr, '0);
		access_and_check(cache_pkg::OP_WRITE, addr, ~word_pattern(addr));
		access_and_check(cache_pkg::OP_READ, addr, '0);
		// Two other tags push the line out
		write_line(0, 8'h47);
		write_line(1, 8'h47);
		access_and_check(cache_pkg::OP_READ, make_addr(0, 8'h47, 0), '0);
		access_and_check(cache_pkg::OP_READ, make_addr(1, 8'h47, 0), '0);
		// Refetch comes from memory
		access_and_check(cache_pkg::OP_READ, addr, '0);
	endtask

	task automatic test_random_mix();
		addr_t addr;
		cache_pkg::cache_op_e op;
		for (int t = 0; t < 4; t++) begin
			write_line(t, 8'h5a);
			write_line(t, 8'ha5);
		end
		for (int n = 0; n < RAND_OPS; n++) begin
			addr = make_addr($urandom % 4, ($urandom % 2) ? 8'ha5 : 8'h5a, $urandom % 4);
			op   = ($urandom % 2) ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
			access_and_check(op, addr, $urandom);
		end
	endtask

	initial begin
		void'($urandom(RAND_SEED));
		clk       = 1'b0;
		rst_n     = 1'b0;
		cpu_req   = 1'b0;
		cpu_op    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		for (int s = 0; s < cache_pkg::SETS; s++) begin
			model_valid[0][s] = 1'b0;
			model_valid[1][s] = 1'b0;
			model_lru[s]      = 1'b0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		test_reset_no_allocate();
		test_line_fill();
		test_lru_replace();
		test_write_hit();
		test_random_mix();
		if (dut0.checker0.failure_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			fail_run("Handshake assertions failed during the run");
		end
	end

endmodule

/* cache_top.f */
hdl/cache_pkg.sv
hdl/cache_ifs.sv
hdl/cache_decode.sv
hdl/cache_execute.sv
hdl/cache_result.sv
hdl/main_memory.sv
hdl/cache_top.sv
verification/cache_checker.sv
verification/cache_tb.sv

/* Bender.yml */
package:
  name: cache_top

sources:
  # RTL in compile order
  - hdl/cache_pkg.sv
  - hdl/cache_ifs.sv
  - hdl/cache_decode.sv
  - hdl/cache_execute.sv
  - hdl/cache_result.sv
  - hdl/main_memory.sv
  - hdl/cache_top.sv
  # Bound checker and testbench
  - target: simulation
    files:
      - verification/cache_checker.sv
      - verification/cache_tb.sv
